// File: fpu_defs.svh
`ifndef FPU_DEFS_SVH
`define FPU_DEFS_SVH

// single precision field widths
`define FPU_EXP_W   8
`define FPU_MAN_W   23
`define FPU_WORD_W  32
`define FPU_EXC_W   4

`define FPU_BIAS    127
`define FPU_EXP_MAX 255   // inf or nan

// raw instruction fields
`define FPU_OP1_COP1 6'b010001
`define FPU_FMT_S    5'b10000
`define FPU_FMT_W    5'b00100
`define FPU_FMT_D0   5'b00000

// op2 codes, add/sub is 00000x and mul, div, floor fall to invalid
`define FPU_OP2_ABS  6'b000101
`define FPU_OP2_NEG  6'b000111
`define FPU_OP2_CVT  6'b000000

// bit positions in the exception code
`define FPU_EXC_OVF     0
`define FPU_EXC_NAN     1
`define FPU_EXC_DIV0    2
`define FPU_EXC_INVALID 3

`endif

// File: fpu_pkg.sv
`include "fpu_defs.svh"

package fpu_pkg;

	// ieee single layout, msb first
	typedef struct packed {
		logic                  sign;
		logic [`FPU_EXP_W-1:0] exp;
		logic [`FPU_MAN_W-1:0] man;   // hidden bit not stored
	} fpu_float_t;

	// fields pulled from the cop1 instruction word
	typedef struct packed {
		logic [5:0] op1;   // bits 31:26
		logic [4:0] fmt;   // bits 25:21
		logic [5:0] op2;   // bits 5:0
	} fpu_instr_t;

	// decoded operation
	typedef enum logic [2:0] {
		OP_ADD,
		OP_SUB,
		OP_ABS,
		OP_NEG,
		OP_FTOI,
		OP_ITOF,
		OP_INVALID
	} fpu_op_t;

	// registered unit output
	typedef struct packed {
		logic [`FPU_WORD_W-1:0] value;
		logic [`FPU_EXC_W-1:0]  exc;   // ovf, nan, div0, invalid
	} fpu_res_t;

endpackage

// File: fpu_lzc.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_lzc #(
	parameter int WIDTH = 32
) (
	input  logic [WIDTH-1:0]           value,
	output logic [$clog2(WIDTH+1)-1:0] count,
	output logic                       zero
);
	localparam int CW = $clog2(WIDTH + 1);

	// scan upward so the highest set bit wins
	always_comb begin
		count = CW'(WIDTH);   // all zero input
		for (int i = 0; i < WIDTH; i++) begin
			if (value[i]) begin
				count = CW'(WIDTH - 1 - i);
			end
		end
	end

	assign zero = ~|value;

endmodule

`default_nettype wire

// File: fpu_addsub.sv
`timescale 1ns/1ps
`default_nettype none
`include "fpu_defs.svh"

module fpu_addsub import fpu_pkg::*; (
	input  fpu_float_t a,
	input  fpu_float_t b,
	input  logic       sub,
	output fpu_float_t sum,
	output logic       ovf
);
	localparam int EW  = `FPU_EXP_W;
	localparam int MW  = `FPU_MAN_W;
	localparam int FW  = MW + 4;   // hidden, mantissa, guard, round, sticky
	localparam int LZW = $clog2(FW + 1);

	wire b_sign = b.sign ^ sub;   // sign of b as it enters the sum

	wire a_spec = (a.exp == EW'(`FPU_EXP_MAX));
	wire b_spec = (b.exp == EW'(`FPU_EXP_MAX));
	wire a_nan  = a_spec && (a.man != '0);
	wire b_nan  = b_spec && (b.man != '0);

	// zero exponent means subnormal, no hidden bit and weight of exponent 1
	wire [MW:0]   a_m = {a.exp != '0, a.man};
	wire [MW:0]   b_m = {b.exp != '0, b.man};
	wire [EW-1:0] a_e = (a.exp == '0) ? EW'(1) : a.exp;
	wire [EW-1:0] b_e = (b.exp == '0) ? EW'(1) : b.exp;

	// w is the larger magnitude, l the smaller
	wire          a_ge = {a.exp, a.man} >= {b.exp, b.man};
	wire [EW-1:0] e_w  = a_ge ? a_e : b_e;
	wire [EW-1:0] e_l  = a_ge ? b_e : a_e;
	wire [MW:0]   m_w  = a_ge ? a_m : b_m;
	wire [MW:0]   m_l  = a_ge ? b_m : a_m;

	// align l, everything below the round bit folds into sticky
	wire [EW-1:0]    e_diff = e_w - e_l;
	wire [MW+FW-1:0] l_wide = {m_l, {(FW-1){1'b0}}} >> e_diff;
	wire [FW-1:0]    m_l_al = {l_wide[MW+FW-1 -: FW-1], |l_wide[MW:0]};

	// effective add, at most one bit of carry
	wire [FW:0]   add_raw = {1'b0, m_w, 3'b000} + {1'b0, m_l_al};
	wire          add_c   = add_raw[FW];
	wire [FW-1:0] add_m   = add_c ? {add_raw[FW:2], |add_raw[1:0]} : add_raw[FW-1:0];
	wire [EW:0]   add_e   = {1'b0, e_w} + (EW+1)'(add_c);

	// effective subtract, never negative after ordering
	wire [FW-1:0]  sub_raw = {m_w, 3'b000} - m_l_al;
	logic [LZW-1:0] sub_lz;
	logic           sub_zero;

	fpu_lzc #(
		.WIDTH(FW)
	) u_lzc (
		.value(sub_raw),
		.count(sub_lz),
		.zero (sub_zero)
	);

	// stop the left shift at exponent 1 so small results stay subnormal
	wire          sub_fit = EW'(sub_lz) < e_w;
	wire [FW-1:0] sub_m   = sub_fit ? (sub_raw << sub_lz) : (sub_raw << (e_w - 1'b1));
	wire [EW:0]   sub_e   = sub_fit ? {1'b0, e_w - EW'(sub_lz)} : (EW+1)'(1);

	wire          eff_add = (a.sign == b_sign);
	wire [FW-1:0] m_n     = eff_add ? add_m : sub_m;
	wire [EW:0]   e_n     = eff_add ? add_e : sub_e;

	// round to nearest even on guard with round and sticky
	wire          rnd_up = m_n[2] & (m_n[3] | m_n[1] | m_n[0]);
	wire [MW+1:0] m_r    = {1'b0, m_n[FW-1:3]} + (MW+2)'(rnd_up);
	wire [EW:0]   e_r    = e_n + (EW+1)'(m_r[MW+1]);   // mantissa wraps to zero on carry
	wire          hidden = m_r[MW+1] | m_r[MW];
	wire          r_ovf  = (e_r >= (EW+1)'(`FPU_EXP_MAX));

	// exact cancellation gives +0
	wire s_r = eff_add ? a.sign : (sub_zero ? 1'b0 : (a_ge ? a.sign : b_sign));

	always_comb begin
		if (a_spec && !b_spec) begin
			sum = {a.sign, a.exp, a_nan, a.man[MW-2:0]};   // quiet bit set on nan
		end else if (!a_spec && b_spec) begin
			sum = {b_sign, b.exp, b_nan, b.man[MW-2:0]};
		end else if (a_spec && b_spec) begin
			if (b_nan)
				sum = {b.sign, b.exp, 1'b1, b.man[MW-2:0]};
			else if (a_nan)
				sum = {a.sign, a.exp, 1'b1, a.man[MW-2:0]};
			else if (a.sign == b_sign)
				sum = {a.sign, EW'(`FPU_EXP_MAX), {MW{1'b0}}};
			else
				sum = {1'b1, EW'(`FPU_EXP_MAX), 1'b1, {(MW-1){1'b0}}};   // inf - inf
		end else if (r_ovf) begin
			sum = {s_r, EW'(`FPU_EXP_MAX), {MW{1'b0}}};
		end else begin
			sum = {s_r, hidden ? e_r[EW-1:0] : {EW{1'b0}}, m_r[MW-1:0]};
		end
	end

	assign ovf = !a_spec && !b_spec && r_ovf;

endmodule

`default_nettype wire

// File: fpu_convert.sv
`timescale 1ns/1ps
`default_nettype none
`include "fpu_defs.svh"

module fpu_convert import fpu_pkg::*; (
	input  fpu_float_t             f_in,
	input  logic [`FPU_WORD_W-1:0] i_in,
	output logic [`FPU_WORD_W-1:0] ftoi,
	output logic                   ftoi_ovf,
	output logic                   ftoi_nan,
	output fpu_float_t             itof
);
	localparam int WW  = `FPU_WORD_W;
	localparam int MW  = `FPU_MAN_W;
	localparam int EW  = `FPU_EXP_W;
	localparam int SHW = $clog2(WW);
	localparam int LZW = $clog2(WW + 1);

	// float to integer
	wire [MW:0]    f_m  = {f_in.exp != '0, f_in.man};
	wire [EW-1:0]  f_sh = f_in.exp - EW'(`FPU_BIAS);

	// integer part on top, half bit right below it
	// exponent bias-1 is 0.5..1, the hidden bit sits on the half position
	wire [WW+MW:0] f_fix = (f_in.exp == EW'(`FPU_BIAS - 1)) ? {{WW{1'b0}}, f_m} :
	                       ({{(WW-1){1'b0}}, f_m, 1'b0} << f_sh[SHW-1:0]);

	// half away from zero, one spare bit for the carry
	wire [WW:0] f_rnd  = {1'b0, f_fix[WW+MW -: WW]} + (WW+1)'(f_fix[MW]);
	wire        f_tiny = f_in.exp < EW'(`FPU_BIAS - 1);   // below one half
	wire        f_huge = f_in.exp > EW'(`FPU_BIAS + WW - 1);
	wire        f_min  = f_in.sign && (f_rnd == {2'b01, {(WW-1){1'b0}}});   // -2^31
	wire        f_big  = f_rnd[WW] | f_rnd[WW-1];

	assign ftoi_nan = (f_in.exp == EW'(`FPU_EXP_MAX)) && (f_in.man != '0);
	assign ftoi_ovf = !ftoi_nan && (f_huge || (!f_tiny && f_big && !f_min));
	assign ftoi = (ftoi_nan || ftoi_ovf || f_tiny) ? '0 :
	              f_in.sign ? -f_rnd[WW-1:0] :   // -2^31 negates to itself
	              f_rnd[WW-1:0];

	// integer to float
	wire           i_neg = i_in[WW-1];
	wire [WW-1:0]  i_mag = i_neg ? -i_in : i_in;
	logic [LZW-1:0] i_lz;
	logic           i_zero;

	fpu_lzc #(
		.WIDTH(WW)
	) u_lzc (
		.value(i_mag),
		.count(i_lz),
		.zero (i_zero)
	);

	wire [WW-1:0] i_norm = i_mag << i_lz;   // leading one at the msb

	// lsb at WW-MW-1, guard below it, the rest is sticky
	wire          i_rnd = i_norm[WW-MW-2] &
	                      (i_norm[WW-MW-1] | (|i_norm[WW-MW-3:0]));
	wire [MW+1:0] i_m   = {1'b0, i_norm[WW-1 -: MW+1]} + (MW+2)'(i_rnd);
	wire [EW-1:0] i_e   = EW'(`FPU_BIAS + WW - 1) - EW'(i_lz) + EW'(i_m[MW+1]);

	assign itof = i_zero ? '0 : {i_neg, i_e, i_m[MW-1:0]};   // carry leaves zero mantissa

endmodule

`default_nettype wire

// File: fpu_issue.sv
`timescale 1ns/1ps
`default_nettype none
`include "fpu_defs.svh"

module fpu_issue import fpu_pkg::*; (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   issue,
	input  fpu_instr_t             instr,
	input  fpu_float_t             x1,
	input  fpu_float_t             sum,
	input  logic                   sum_ovf,
	input  logic [`FPU_WORD_W-1:0] ftoi,
	input  logic                   ftoi_ovf,
	input  logic                   ftoi_nan,
	input  fpu_float_t             itof,
	output fpu_res_t               result,
	output logic                   done
);
	fpu_op_t  op;
	fpu_res_t res_d;

	// opcode decode, anything unmatched is invalid
	always_comb begin
		op = OP_INVALID;
		if (instr.op1 == `FPU_OP1_COP1) begin
			case (instr.fmt)
				`FPU_FMT_S: begin
					if (instr.op2[5:1] == 5'd0)
						op = instr.op2[0] ? OP_SUB : OP_ADD;
					else if (instr.op2 == `FPU_OP2_ABS)
						op = OP_ABS;
					else if (instr.op2 == `FPU_OP2_NEG)
						op = OP_NEG;
				end
				`FPU_FMT_D0: begin
					if (instr.op2 == `FPU_OP2_CVT)
						op = OP_FTOI;
				end
				`FPU_FMT_W: begin
					if (instr.op2 == `FPU_OP2_CVT)
						op = OP_ITOF;
				end
				default: op = OP_INVALID;
			endcase
		end
	end

	always_comb begin
		res_d = '0;
		case (op)
			OP_ADD, OP_SUB: begin
				res_d.value = sum;
				res_d.exc[`FPU_EXC_OVF] = sum_ovf;
			end
			OP_ABS:  res_d.value = {1'b0, x1.exp, x1.man};
			OP_NEG:  res_d.value = {~x1.sign, x1.exp, x1.man};
			OP_FTOI: begin
				res_d.value = ftoi;
				res_d.exc[`FPU_EXC_OVF] = ftoi_ovf;
				res_d.exc[`FPU_EXC_NAN] = ftoi_nan;
			end
			OP_ITOF: res_d.value = itof;
			default: res_d.exc[`FPU_EXC_INVALID] = 1'b1;   // value stays 0
		endcase
		res_d.exc[`FPU_EXC_DIV0] = 1'b0;   // no divider in this unit
	end

	// one cycle from issue to done
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			result <= '0;
			done   <= 1'b0;
		end else begin
			done <= issue;
			if (issue)
				result <= res_d;
		end
	end

endmodule

`default_nettype wire

// File: fpu_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "fpu_defs.svh"

module fpu_top import fpu_pkg::*; (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   issue,
	input  fpu_instr_t             instr,
	input  logic [`FPU_WORD_W-1:0] x1,
	input  logic [`FPU_WORD_W-1:0] x2,
	output fpu_res_t               result,
	output logic                   done
);
	fpu_float_t             x1_f;
	fpu_float_t             x2_f;
	fpu_float_t             sum;
	logic                   sum_ovf;
	logic [`FPU_WORD_W-1:0] ftoi;
	logic                   ftoi_ovf;
	logic                   ftoi_nan;
	fpu_float_t             itof;

	assign x1_f = x1;
	assign x2_f = x2;

	fpu_addsub u_addsub (
		.a  (x1_f),
		.b  (x2_f),
		.sub(instr.op2[0]),   // op2 lsb selects subtract
		.sum(sum),
		.ovf(sum_ovf)
	);

	// ftoi reads fs, itof reads ft
	fpu_convert u_convert (
		.f_in    (x1_f),
		.i_in    (x2),
		.ftoi    (ftoi),
		.ftoi_ovf(ftoi_ovf),
		.ftoi_nan(ftoi_nan),
		.itof    (itof)
	);

	fpu_issue u_issue (
		.clk     (clk),
		.arst_n  (arst_n),
		.issue   (issue),
		.instr   (instr),
		.x1      (x1_f),
		.sum     (sum),
		.sum_ovf (sum_ovf),
		.ftoi    (ftoi),
		.ftoi_ovf(ftoi_ovf),
		.ftoi_nan(ftoi_nan),
		.itof    (itof),
		.result  (result),
		.done    (done)
	);

endmodule

`default_nettype wire

// File: fpu_top_props.sv
`timescale 1ns/1ps
`include "fpu_defs.svh"

module fpu_top_props import fpu_pkg::*; (
	input logic     clk,
	input logic     arst_n,
	input logic     issue,
	input fpu_res_t result,
	input logic     done
);

	// done is issue delayed by one cycle
	a_done_after_issue: assert property (
		@(posedge clk) disable iff (!arst_n) issue |=> done
	) else $error("done missing one cycle after issue");

	a_no_extra_done: assert property (
		@(posedge clk) disable iff (!arst_n) !issue |=> !done
	) else $error("done high without an issue in the cycle before");

	a_done_low_in_reset: assert property (
		@(posedge clk) !arst_n |-> !done
	) else $error("done high while reset is asserted");

	// invalid ops carry a zero value
	a_invalid_zero: assert property (
		@(posedge clk) disable iff (!arst_n)
		result.exc[`FPU_EXC_INVALID] |-> (result.value == '0)
	) else $error("invalid exception with a nonzero value");

endmodule

// File: fpu_top_tb.sv
`timescale 1ns/1ps
`include "fpu_defs.svh"

module fpu_top_tb import fpu_pkg::*; ();
	// about 50 cycles of tests after reset plus margin
	localparam int TIMEOUT_CYCLES = 400;

	localparam fpu_instr_t I_ADD  = {`FPU_OP1_COP1, `FPU_FMT_S, 6'd0};
	localparam fpu_instr_t I_SUB  = {`FPU_OP1_COP1, `FPU_FMT_S, 6'd1};
	localparam fpu_instr_t I_MUL  = {`FPU_OP1_COP1, `FPU_FMT_S, 6'd2};   // dropped multiply
	localparam fpu_instr_t I_BAD  = {`FPU_OP1_COP1, `FPU_FMT_S, 6'h3f};
	localparam fpu_instr_t I_ABS  = {`FPU_OP1_COP1, `FPU_FMT_S, `FPU_OP2_ABS};
	localparam fpu_instr_t I_NEG  = {`FPU_OP1_COP1, `FPU_FMT_S, `FPU_OP2_NEG};
	localparam fpu_instr_t I_FTOI = {`FPU_OP1_COP1, `FPU_FMT_D0, `FPU_OP2_CVT};
	localparam fpu_instr_t I_ITOF = {`FPU_OP1_COP1, `FPU_FMT_W, `FPU_OP2_CVT};

	logic        clk = 1'b0;
	logic        arst_n;
	logic        issue;
	fpu_instr_t  instr;
	logic [31:0] x1;
	logic [31:0] x2;
	fpu_res_t    result;
	logic        done;

	int          errors;
	int          checks;
	int          cycles;
	logic [15:0] lfsr_state = 16'd44173;

	fpu_top DUT (.clk, .arst_n, .issue, .instr, .x1, .x2, .result, .done);

	bind fpu_top fpu_top_props props (.clk, .arst_n, .issue, .result, .done);

	always #2 clk = ~clk;

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
		lfsr_state = {lfsr_state[14:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] w;
		w = '0;
		for (int i = 0; i < n; i++)
			w = {w[30:0], lfsr_bit()};
		return w;
	endfunction

	// integer to single for magnitudes below 2^24
	function automatic logic [31:0] exact_float(input logic [31:0] v);
		logic [31:0] mag;
		logic [31:0] frac;
		int          msb;
		mag = v[31] ? -v : v;
		msb = 0;
		for (int i = 0; i < 32; i++)
			if (mag[i])
				msb = i;
		frac = mag << (23 - msb);   // leading one lands on the hidden bit
		if (mag == 32'h0)
			return 32'h0;
		return {v[31], 8'(`FPU_BIAS + msb), frac[22:0]};
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
	                           input logic [31:0] want);
		checks++;
		assert (got === want)
		else begin
			errors++;
			$display("mismatch %s: got 0x%h, expected 0x%h", name, got, want);
		end
	endtask

	// result is registered on the rising edge after the drive
	task automatic run_op(input fpu_instr_t ins, input logic [31:0] a, input logic [31:0] b,
	                      input logic [31:0] want, input logic [3:0] want_exc);
		issue = 1'b1;
		instr = ins;
		x1    = a;
		x2    = b;
		@(negedge clk);
		issue = 1'b0;
		checks++;
		assert (done === 1'b1)
		else begin
			errors++;
			$display("done did not pulse one cycle after issue, op2 0x%h", ins.op2);
		end
		check_value("result.value", result.value, want);
		check_value("result.exc", 32'(result.exc), {28'h0, want_exc});
	endtask

	task automatic add_sub_cases();
		run_op(I_ADD, 32'h3f800000, 32'h40000000, 32'h40400000, 4'h0);   // 1 + 2
		run_op(I_SUB, 32'h3fc00000, 32'h3fc00000, 32'h00000000, 4'h0);   // exact cancel
		run_op(I_ADD, 32'h3f800000, 32'h33800000, 32'h3f800000, 4'h0);   // tie to even
		run_op(I_ADD, 32'h3f800000, 32'h34400000, 32'h3f800002, 4'h0);   // above half ulp
		run_op(I_ADD, 32'h00000001, 32'h00000001, 32'h00000002, 4'h0);
	endtask

	task automatic special_operands();
		run_op(I_ADD, 32'h7f800000, 32'hff800000, 32'hffc00000, 4'h0);
		run_op(I_ADD, 32'h7f800001, 32'h3f800000, 32'h7fc00001, 4'h0);   // gets quieted
		run_op(I_ADD, 32'h7f7fffff, 32'h7f7fffff, 32'h7f800000, 4'h1 << `FPU_EXC_OVF);
	endtask

	task automatic abs_neg_signs();
		logic [31:0] v;
		for (int i = 0; i < 4; i++) begin
			v = random_bits(32);
			run_op(I_ABS, v, 32'h0, {1'b0, v[30:0]}, 4'h0);
			run_op(I_NEG, v, 32'h0, {~v[31], v[30:0]}, 4'h0);
		end
	endtask

	task automatic float_to_int_cases();
		run_op(I_FTOI, 32'h40200000, 32'h0, 32'h00000003, 4'h0);   // 2.5
		run_op(I_FTOI, 32'hc0200000, 32'h0, 32'hfffffffd, 4'h0);   // -2.5
		run_op(I_FTOI, 32'h3ecccccd, 32'h0, 32'h00000000, 4'h0);   // 0.4
		run_op(I_FTOI, 32'hcf000000, 32'h0, 32'h80000000, 4'h0);
		run_op(I_FTOI, 32'h4f000000, 32'h0, 32'h00000000, 4'h1 << `FPU_EXC_OVF);
		run_op(I_FTOI, 32'h7fc00000, 32'h0, 32'h00000000, 4'h1 << `FPU_EXC_NAN);
	endtask

	task automatic int_to_float_cases();
		logic [31:0] v;
		for (int i = 0; i < 8; i++) begin
			v = random_bits(24);
			if (lfsr_bit())
				v = -v;
			run_op(I_ITOF, 32'h0, v, exact_float(v), 4'h0);
		end
		run_op(I_ITOF, 32'h0, 32'h00000000, 32'h00000000, 4'h0);
		run_op(I_ITOF, 32'h0, 32'h01000001, 32'h4b800000, 4'h0);   // rounds to 2^24
	endtask

	task automatic invalid_opcodes();
		run_op(I_BAD, 32'h3f800000, 32'h3f800000, 32'h0, 4'h1 << `FPU_EXC_INVALID);
		run_op(I_MUL, 32'h3f800000, 32'h40000000, 32'h0, 4'h1 << `FPU_EXC_INVALID);
	endtask

	task automatic back_to_back_issues();
		run_op(I_ADD, 32'h3f800000, 32'h40000000, 32'h40400000, 4'h0);
		run_op(I_FTOI, 32'h40200000, 32'h0, 32'h00000003, 4'h0);
		run_op(I_NEG, 32'h3f800000, 32'h0, 32'hbf800000, 4'h0);
		@(negedge clk);
		checks++;
		assert (done === 1'b0)
		else begin
			errors++;
			$display("done stayed high in a cycle without issue");
		end
	endtask

	initial begin
		errors = 0;
		checks = 0;
		arst_n = 1'b0;
		issue  = 1'b0;
		instr  = '0;
		x1     = '0;
		x2     = '0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		checks++;
		assert (done === 1'b0 && result === '0)
		else begin
			errors++;
			$display("outputs were not cleared by reset");
		end
		add_sub_cases();
		special_operands();
		abs_neg_signs();
		float_to_int_cases();
		int_to_float_cases();
		invalid_opcodes();
		back_to_back_issues();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// File: fpu_top.f
+incdir+.
fpu_pkg.sv
fpu_lzc.sv
fpu_addsub.sv
fpu_convert.sv
fpu_issue.sv
fpu_top.sv
fpu_top_props.sv
fpu_top_tb.sv

// File: run.sh
#!/bin/sh
# build and run the fpu testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f fpu_top.f \
	--top-module fpu_top_tb -o fpu_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/fpu_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
	echo "simulation exited with an error, see sim.log"
	exit 1
fi

if grep -q "TESTBENCH PASSED" sim.log; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed, see sim.log"
exit 1
